// ==== hdl/gearbox_pkg.sv ====
package gearbox_pkg;

	// Word widths on both sides of the gearbox
	localparam int in_width = 48;
	localparam int out_width = 32;
	localparam int hdr_width = 2;

	// A header word carries the sync header on top of the source bits
	localparam int framed_width = in_width + hdr_width;

	localparam int buf_width = 100; // Bit buffer between framer and output

	typedef logic [7:0] fill_t;

	localparam fill_t fill_init = 8'd60; // Start level after reset or underflow
	localparam fill_t fill_ready_max = 8'd80; // Source may pop below this level

	// Highest level at which a plain 48-bit word still fits after the drain
	localparam fill_t fill_max = fill_t'(buf_width + out_width - in_width);

	// Four source words make three 66-bit blocks, so the header moves each pop
	typedef enum logic [1:0] {
		phase_plain,
		phase_hdr_16,
		phase_hdr_32,
		phase_hdr_tail
	} phase_t;

	// Header inside a word has bit 1 set, header at the tail has bit 0 set
	localparam logic [hdr_width-1:0] hdr_mid = 2'b10;
	localparam logic [hdr_width-1:0] hdr_tail = 2'b01;

endpackage

// ==== hdl/framed_word_if.sv ====
`timescale 1ns/1ns

interface framed_word_if;

	logic valid; // A pop is taken this cycle
	logic [gearbox_pkg::framed_width-1:0] data; // Right aligned framed word
	gearbox_pkg::fill_t len; // Number of valid bits in data
	gearbox_pkg::phase_t phase; // Header placement used for this word

	modport framer (
		output valid,
		output data,
		output len,
		output phase
	);

	modport buffer (
		input valid,
		input data,
		input len,
		input phase
	);

endinterface

// ==== hdl/block_framer.sv ====
`timescale 1ns/1ns

module block_framer (
	input logic clk,
	input logic reset_n,
	input logic enable,
	input logic pop,
	input logic [gearbox_pkg::in_width-1:0] in_data,
	framed_word_if.framer fw
);

	gearbox_pkg::phase_t phase_q;
	gearbox_pkg::phase_t phase_nxt;

	// The phase steps once per accepted word and wraps after four words
	always_comb begin
		case (phase_q)
			gearbox_pkg::phase_plain: phase_nxt = gearbox_pkg::phase_hdr_16;
			gearbox_pkg::phase_hdr_16: phase_nxt = gearbox_pkg::phase_hdr_32;
			gearbox_pkg::phase_hdr_32: phase_nxt = gearbox_pkg::phase_hdr_tail;
			default: phase_nxt = gearbox_pkg::phase_plain;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			phase_q <= gearbox_pkg::phase_plain;
		end else if (enable && pop) begin
			phase_q <= phase_nxt;
		end
	end

	// Header position follows the phase
	always_comb begin
		case (phase_q)
			gearbox_pkg::phase_plain: begin
				fw.data = {{gearbox_pkg::hdr_width{1'b0}}, in_data};
				fw.len = gearbox_pkg::fill_t'(gearbox_pkg::in_width);
			end
			gearbox_pkg::phase_hdr_16: begin
				fw.data = {
					in_data[gearbox_pkg::in_width-1:16],
					gearbox_pkg::hdr_mid,
					in_data[15:0]
				};
				fw.len = gearbox_pkg::fill_t'(gearbox_pkg::framed_width);
			end
			gearbox_pkg::phase_hdr_32: begin
				fw.data = {
					in_data[gearbox_pkg::in_width-1:32],
					gearbox_pkg::hdr_mid,
					in_data[31:0]
				};
				fw.len = gearbox_pkg::fill_t'(gearbox_pkg::framed_width);
			end
			default: begin
				fw.data = {gearbox_pkg::hdr_tail, in_data}; // Closes the third block
				fw.len = gearbox_pkg::fill_t'(gearbox_pkg::framed_width);
			end
		endcase
	end

	assign fw.valid = enable & pop;
	assign fw.phase = phase_q;

endmodule

// ==== hdl/bit_buffer.sv ====
`timescale 1ns/1ns

module bit_buffer (
	input logic clk,
	input logic reset_n,
	input logic enable,
	framed_word_if.buffer fw,
	output logic [gearbox_pkg::out_width-1:0] out_data,
	output logic ready,
	output logic fault
);

	logic [gearbox_pkg::buf_width-1:0] buf_q;
	logic [gearbox_pkg::buf_width-1:0] buf_nxt;
	logic [gearbox_pkg::buf_width-1:0] shifted;
	logic [gearbox_pkg::buf_width-1:0] word_ext;
	logic [gearbox_pkg::buf_width-1:0] len_mask;
	gearbox_pkg::fill_t fill_q;
	gearbox_pkg::fill_t fill_nxt;
	gearbox_pkg::fill_t wr_pos;
	logic drain_ok;
	logic fits_hdr;
	logic pop_legal;

	// A full output word must be present before anything moves
	assign drain_ok = fill_q >= gearbox_pkg::fill_t'(gearbox_pkg::out_width);

	// After the drain the new word lands right above the remaining bits
	assign wr_pos = fill_q - gearbox_pkg::fill_t'(gearbox_pkg::out_width);

	// A header word is two bits longer, so its limit sits two levels lower
	assign fits_hdr = wr_pos <=
		gearbox_pkg::fill_t'(gearbox_pkg::buf_width - gearbox_pkg::framed_width);

	always_comb begin
		pop_legal = fw.valid && drain_ok && !fill_q[0];
		if (fill_q > gearbox_pkg::fill_max) begin
			pop_legal = 1'b0;
		end
		if (fw.phase != gearbox_pkg::phase_plain && !fits_hdr) begin
			pop_legal = 1'b0;
		end
	end

	assign word_ext = {
		{(gearbox_pkg::buf_width - gearbox_pkg::framed_width){1'b0}},
		fw.data
	};
	assign len_mask = ~({gearbox_pkg::buf_width{1'b1}} << fw.len); // Low len bits set

	assign shifted = buf_q >> gearbox_pkg::out_width;

	always_comb begin
		buf_nxt = buf_q; // Underflow holds the contents
		fill_nxt = gearbox_pkg::fill_init;
		if (drain_ok) begin
			buf_nxt = shifted;
			fill_nxt = wr_pos;
			if (pop_legal) begin
				// Bits above the new word keep the shifted contents
				buf_nxt = (shifted & ~(len_mask << wr_pos)) |
					((word_ext & len_mask) << wr_pos);
				fill_nxt = wr_pos + fw.len;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			buf_q <= '0;
			fill_q <= gearbox_pkg::fill_init;
		end else if (enable) begin
			buf_q <= buf_nxt;
			fill_q <= fill_nxt;
		end
	end

	assign out_data = buf_q[gearbox_pkg::out_width-1:0];

	assign ready = fill_q < gearbox_pkg::fill_ready_max;

	// Either the buffer ran dry or the source popped at a bad level
	assign fault = !drain_ok || (fw.valid && !pop_legal);

endmodule

// ==== hdl/tx_gearbox.sv ====
`timescale 1ns/1ns

module tx_gearbox (
	input logic clk,
	input logic reset_n,
	input logic enable,
	input logic pop,
	input logic [gearbox_pkg::in_width-1:0] in_data,
	output logic [gearbox_pkg::out_width-1:0] out_data,
	output logic ready,
	output logic fault
);

	framed_word_if fw ();

	// Inserts the sync header according to the block phase
	block_framer u_block_framer (
		.clk(clk),
		.reset_n(reset_n),
		.enable(enable),
		.pop(pop),
		.in_data(in_data),
		.fw(fw.framer)
	);

	// Packs framed words into the buffer and drains 32 bits per cycle
	bit_buffer u_bit_buffer (
		.clk(clk),
		.reset_n(reset_n),
		.enable(enable),
		.fw(fw.buffer),
		.out_data(out_data),
		.ready(ready),
		.fault(fault)
	);

endmodule

// ==== test/tx_gearbox_chk.sv ====
`timescale 1ns/1ns

module tx_gearbox_chk (
	input logic clk,
	input logic reset_n,
	input logic enable,
	input logic pop,
	input logic ready,
	input logic fault,
	input logic [gearbox_pkg::out_width-1:0] out_data,
	input gearbox_pkg::fill_t fill_level
);

	int fail_count = 0;

	// Without a pop only an empty buffer can raise fault
	a_no_fault: assert property (@(posedge clk) disable iff (!reset_n)
		(ready && !pop && fill_level >= 8'd32) |-> !fault)
	else begin
		fail_count++;
		$error("fault high without a pop at a legal fill level");
	end

	a_hold: assert property (@(posedge clk) disable iff (!reset_n)
		!enable |=> $stable(out_data))
	else begin
		fail_count++;
		$error("out_data changed while enable was low");
	end

	a_reset: assert property (@(posedge clk) !reset_n |=> (ready && !fault))
	else begin
		fail_count++;
		$error("ready low or fault high after a reset edge");
	end

endmodule

// ==== test/tb_tx_gearbox.sv ====
`timescale 1ns/1ns

module tb_tx_gearbox;

	logic clk;
	logic reset_n;
	logic enable;
	logic pop;
	logic [gearbox_pkg::in_width-1:0] in_data;
	logic [gearbox_pkg::out_width-1:0] out_data;
	logic ready;
	logic fault;

	bit model_q[$]; // Expected stream, the front bit is out_data bit 0
	int model_phase;
	int checks;
	int errors;
	logic [31:0] lcg_state;
	logic [31:0] last_out;
	logic last_fault;

	tx_gearbox u_tx_gearbox (
		.clk(clk),
		.reset_n(reset_n),
		.enable(enable),
		.pop(pop),
		.in_data(in_data),
		.out_data(out_data),
		.ready(ready),
		.fault(fault)
	);

	bind tx_gearbox tx_gearbox_chk u_chk (
		.clk(clk),
		.reset_n(reset_n),
		.enable(enable),
		.pop(pop),
		.ready(ready),
		.fault(fault),
		.out_data(out_data),
		.fill_level(u_bit_buffer.fill_q)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [47:0] random_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[15:0], lo};
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// Level must allow the drain, be even and leave room for the word
	function automatic bit pop_is_legal(int level, int phase);
		if (level < 32 || level % 2 != 0) return 1'b0;
		if (level > 84) return 1'b0;
		if (phase != 0 && level > 82) return 1'b0; // Header words are two bits longer
		return 1'b1;
	endfunction

	task automatic append_word(input logic [47:0] d, input int phase);
		for (int i = 0; i < 48; i++) begin
			if ((phase == 1 && i == 16) || (phase == 2 && i == 32)) begin
				model_q.push_back(1'b0);
				model_q.push_back(1'b1);
			end
			model_q.push_back(d[i]);
		end
		if (phase == 3) begin
			model_q.push_back(1'b1); // Tail header closes the third block
			model_q.push_back(1'b0);
		end
	endtask

	function automatic logic [31:0] model_word();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			if (i < model_q.size()) w[i] = model_q[i];
		end
		return w;
	endfunction

	task automatic run_cycle(input logic en, input logic p, input logic [47:0] d);
		int level;
		logic exp_fault;
		@(posedge clk);
		enable <= en;
		pop <= p;
		in_data <= d;
		@(negedge clk);
		level = model_q.size();
		exp_fault = level < 32 || (en && p && !pop_is_legal(level, model_phase));
		check_value("out_data", 64'(out_data), 64'(model_word()));
		check_value("ready", 64'(ready), 64'(level < 80));
		check_value("fault", 64'(fault), 64'(exp_fault));
		last_out = out_data;
		last_fault = fault;
		if (en) begin
			if (level >= 32) begin
				repeat (32) model_q.delete(0);
				if (p && pop_is_legal(level, model_phase)) append_word(d, model_phase);
			end else begin
				// Held buffer reads as zeros above the old level
				while (model_q.size() < 60) model_q.push_back(1'b0);
			end
			if (p) model_phase = (model_phase + 1) % 4;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset_n <= 1'b0;
		enable <= 1'b0;
		pop <= 1'b0;
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;
		model_q.delete();
		repeat (60) model_q.push_back(1'b0); // Buffer starts 60 bits deep
		model_phase = 0;
	endtask

	task automatic test_reset_state();
		apply_reset();
		run_cycle(1'b0, 1'b0, '0);
		check_value("ready after reset", 64'(ready), 64'd1);
		check_value("fault after reset", 64'(fault), 64'd0);
		check_value("first out_data", 64'(out_data), 64'd0);
	endtask

	task automatic test_throughput();
		int pops;
		logic p;
		pops = 0;
		for (int n = 0; n < 40; n++) begin
			p = ready;
			run_cycle(1'b1, p, random_word());
			if (p) pops++;
		end
		check_value("pop count", 64'(pops >= 24), 64'd1);
	endtask

	task automatic test_phase_cycle();
		bit stream[$];
		int pops;
		int n;
		int off;
		logic p;
		apply_reset();
		pops = 0;
		n = 0;
		while ((pops < 4 || stream.size() < 258) && n < 20) begin
			p = pops < 4 && model_q.size() < 80;
			run_cycle(1'b1, p, '0);
			if (p) pops++;
			for (int i = 0; i < 32; i++) stream.push_back(last_out[i]);
			n++;
		end
		if (n == 20) begin
			errors++;
			$display("timeout: phase test did not collect 258 stream bits");
		end else begin
			// Zero words leave only the set bit of each header in the stream
			for (int i = 0; i < 258; i++) begin
				off = i - 60;
				check_value($sformatf("stream bit %0d", i), 64'(stream[i]),
					64'(off == 65 || off == 131 || off == 196));
			end
		end
	endtask

	task automatic test_enable_gating();
		logic [31:0] held_out;
		logic held_ready;
		for (int n = 0; n < 8; n++) begin
			run_cycle(1'b1, model_q.size() < 80, random_word());
		end
		run_cycle(1'b0, 1'b1, random_word());
		held_out = last_out;
		held_ready = ready;
		for (int n = 0; n < 9; n++) begin
			run_cycle(1'b0, 1'b1, random_word()); // Pops without enable are ignored
			check_value("gated out_data", 64'(last_out), 64'(held_out));
			check_value("gated ready", 64'(ready), 64'(held_ready));
		end
		for (int n = 0; n < 12; n++) begin
			run_cycle(1'b1, model_q.size() < 80, random_word());
		end
	endtask

	task automatic test_underflow();
		int n;
		bit seen_low;
		apply_reset();
		run_cycle(1'b1, 1'b0, '0);
		run_cycle(1'b1, 1'b0, '0); // Level is 28 here
		check_value("fault at level 28", 64'(last_fault), 64'd1);
		check_value("ready at level 28", 64'(ready), 64'd1);
		n = 0;
		seen_low = 1'b0;
		while (!seen_low && n < 10) begin
			run_cycle(1'b1, model_q.size() < 80, random_word());
			seen_low = !last_fault;
			n++;
		end
		if (!seen_low) begin
			errors++;
			$display("timeout: fault stayed high after the underflow");
		end
		for (int k = 0; k < 8; k++) begin
			run_cycle(1'b1, model_q.size() < 80, random_word());
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset_n = 1'b0;
		enable = 1'b0;
		pop = 1'b0;
		in_data = '0;
		lcg_state = 32'd42;
		checks = 0;
		errors = 0;
		test_reset_state();
		test_throughput();
		test_phase_cycle();
		test_enable_gating();
		test_underflow();
		errors += u_tx_gearbox.u_chk.fail_count;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
hdl/gearbox_pkg.sv
hdl/framed_word_if.sv
hdl/block_framer.sv
hdl/bit_buffer.sv
hdl/tx_gearbox.sv
test/tx_gearbox_chk.sv
test/tb_tx_gearbox.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_tx_gearbox
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG = TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
